// ==== rtl/btc_pkg.sv ====
// sizes, vector types and request/response structs of the branch target cache
`default_nettype none

package btc_pkg;

    // ----------------------------------------------------------------------
    // sizes

    localparam int UPPER_PC_WIDTH   = 10;
    localparam int LOWER_PC_WIDTH   = 22;
    localparam int UPCT_ENTRIES     = 8;
    localparam int LOG_UPCT_ENTRIES = 3;
    localparam int BTB_SETS         = 64;
    localparam int BTB_TAG_WIDTH    = 8;

    // ----------------------------------------------------------------------
    // vector types

    typedef logic [UPPER_PC_WIDTH+LOWER_PC_WIDTH-1:0] pc_t;
    typedef logic [UPPER_PC_WIDTH-1:0]                upper_pc_t;
    typedef logic [LOWER_PC_WIDTH-1:0]                lower_pc_t;
    typedef logic [LOG_UPCT_ENTRIES-1:0]              upct_index_t;
    // one bit per inner node of the tree
    typedef logic [UPCT_ENTRIES-2:0]                  plru_bits_t;
    typedef logic [$clog2(BTB_SETS)-1:0]              btb_index_t;
    typedef logic [BTB_TAG_WIDTH-1:0]                 btb_tag_t;

    // ----------------------------------------------------------------------
    // structs

    typedef struct packed {
        logic valid;
        pc_t  pc;
    } lookup_req_t;

    // resolved taken branch
    typedef struct packed {
        logic valid;
        pc_t  pc;
        pc_t  target;
    } update_req_t;

    typedef struct packed {
        logic        valid;
        btb_tag_t    tag;
        lower_pc_t   lower;
        upct_index_t upct_index;
    } lower_entry_t;

    typedef struct packed {
        logic        valid;
        logic        hit;
        lower_pc_t   lower;
        upct_index_t upct_index;
    } lookup_result_t;

    typedef struct packed {
        logic valid;
        logic hit;
        pc_t  target;
    } pred_resp_t;

endpackage

`default_nettype wire

// ==== rtl/plru_updater.sv ====
// tree pseudo-LRU victim select with new and touch path update, eight ways
`timescale 1ns/1ns
`default_nettype none

module plru_updater (
    input  btc_pkg::plru_bits_t  plru_in,
    input  logic                 new_valid,
    input  logic                 touch_valid,
    input  btc_pkg::upct_index_t touch_index,
    output btc_pkg::upct_index_t new_index,
    output btc_pkg::plru_bits_t  plru_out
);

    // victim walk with one bit per tree level
    logic                 victim_half;
    logic                 victim_quarter;
    logic                 victim_leaf;

    // path being updated
    btc_pkg::upct_index_t path_index;
    logic [2:0]           path_node1;
    logic [2:0]           path_node2;

    // ----------------------------------------------------------------------
    // victim search

    // root is node 0, children of n are 2n+1 and 2n+2
    assign victim_half    = plru_in[0];
    assign victim_quarter = plru_in[{2'b00, victim_half} + 3'd1];
    assign victim_leaf    = plru_in[{1'b0, victim_half, victim_quarter} + 3'd3];

    assign new_index = {victim_half, victim_quarter, victim_leaf};

    // ----------------------------------------------------------------------
    // path update

    // a new entry takes priority over a touch
    assign path_index = new_valid ? new_index : touch_index;

    assign path_node1 = {2'b00, path_index[2]} + 3'd1;
    assign path_node2 = {1'b0, path_index[2:1]} + 3'd3;

    always_comb begin
        plru_out = plru_in;
        if (new_valid || touch_valid) begin
            // point every node on the path away from this entry
            plru_out[0]          = ~path_index[2];
            plru_out[path_node1] = ~path_index[1];
            plru_out[path_node2] = ~path_index[0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/upct.sv ====
// upper pc table with cam compare, one-cycle update pipeline and plru state
`timescale 1ns/1ns
`default_nettype none

module upct (
    input  logic                                                 CLK,
    input  logic                                                 nRST,
    input  logic                                                 update0_valid,
    input  btc_pkg::pc_t                                         update0_target,
    input  logic                                                 read_valid,
    input  btc_pkg::upct_index_t                                 read_index,
    output btc_pkg::upper_pc_t [btc_pkg::UPCT_ENTRIES-1:0]       upct_array,
    output btc_pkg::upct_index_t                                 update1_index
);

    // table next state
    btc_pkg::upper_pc_t [btc_pkg::UPCT_ENTRIES-1:0] next_upct_array;

    // replacement state
    btc_pkg::plru_bits_t                plru;
    btc_pkg::plru_bits_t                next_plru;
    logic                               plru_new_valid;
    btc_pkg::upct_index_t               plru_new_index;
    logic                               plru_touch_valid;
    btc_pkg::upct_index_t               plru_touch_index;

    // update stage 0
    btc_pkg::upper_pc_t                 update0_upper;
    logic [btc_pkg::UPCT_ENTRIES-1:0]   update0_match;

    // update stage 1
    logic                               update1_valid;
    btc_pkg::upper_pc_t                 update1_upper;
    logic [btc_pkg::UPCT_ENTRIES-1:0]   update1_match;
    logic                               update1_hit;
    btc_pkg::upct_index_t               update1_match_index;

    // ----------------------------------------------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            upct_array    <= '0;
            plru          <= '0;
            update1_valid <= 1'b0;
        end else begin
            upct_array    <= next_upct_array;
            plru          <= next_plru;
            update1_valid <= update0_valid;
        end
    end

    always_ff @(posedge CLK) begin
        update1_upper <= update0_upper;
        update1_match <= update0_match;
    end

    // ----------------------------------------------------------------------
    // update 0 compares against every entry

    assign update0_upper = update0_target[31 -: btc_pkg::UPPER_PC_WIDTH];

    always_comb begin
        for (int i = 0; i < btc_pkg::UPCT_ENTRIES; i++) begin
            update0_match[i] = (upct_array[i] == update0_upper);
        end
    end

    // ----------------------------------------------------------------------
    // update 1 picks the entry and arbitrates plru

    assign update1_hit = |update1_match;

    // lowest matching index wins
    always_comb begin
        update1_match_index = '0;
        for (int i = btc_pkg::UPCT_ENTRIES - 1; i >= 0; i--) begin
            if (update1_match[i]) begin
                update1_match_index = btc_pkg::upct_index_t'(i);
            end
        end
    end

    plru_updater u_plru (
        .plru_in     (plru),
        .new_valid   (plru_new_valid),
        .touch_valid (plru_touch_valid),
        .touch_index (plru_touch_index),
        .new_index   (plru_new_index),
        .plru_out    (next_plru)
    );

    always_comb begin
        next_upct_array  = upct_array;
        plru_new_valid   = 1'b0;
        plru_touch_valid = 1'b0;
        plru_touch_index = read_index;
        update1_index    = plru_new_index;

        if (update1_valid && update1_hit) begin
            // existing upper field, just keep it warm
            update1_index    = update1_match_index;
            plru_touch_valid = 1'b1;
            plru_touch_index = update1_match_index;
        end else if (update1_valid) begin
            // on a miss overwrite the victim
            next_upct_array[plru_new_index] = update1_upper;
            plru_new_valid                  = 1'b1;
        end else if (read_valid) begin
            plru_touch_valid = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/btb_lower_table.sv ====
// direct-mapped lower target table with delayed write of the upct pointer
`timescale 1ns/1ns
`default_nettype none

module btb_lower_table (
    input  logic                    CLK,
    input  logic                    nRST,
    input  btc_pkg::lookup_req_t    lookup,
    input  btc_pkg::update_req_t    update,
    input  btc_pkg::upct_index_t    update1_index,
    output btc_pkg::lookup_result_t result
);

    // entry storage
    btc_pkg::lower_entry_t [btc_pkg::BTB_SETS-1:0] entries;

    // lookup side
    btc_pkg::btb_index_t    lookup_set;
    btc_pkg::btb_tag_t      lookup_tag;
    btc_pkg::lower_entry_t  read_entry;

    // update side
    btc_pkg::btb_index_t    update0_set;
    btc_pkg::btb_tag_t      update0_tag;
    logic                   update1_valid;
    btc_pkg::btb_index_t    update1_set;
    btc_pkg::btb_tag_t      update1_tag;
    btc_pkg::lower_pc_t     update1_lower;
    btc_pkg::lower_entry_t  write_entry;

    // ----------------------------------------------------------------------
    // update pipeline

    // set from pc[7:2], tag from pc[15:8]
    assign update0_set = update.pc[7:2];
    assign update0_tag = update.pc[15:8];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            update1_valid <= 1'b0;
        end else begin
            update1_valid <= update.valid;
        end
    end

    always_ff @(posedge CLK) begin
        update1_set   <= update0_set;
        update1_tag   <= update0_tag;
        update1_lower <= update.target[btc_pkg::LOWER_PC_WIDTH-1:0];
    end

    // pointer only known once upct has resolved the upper field
    always_comb begin
        write_entry.valid      = 1'b1;
        write_entry.tag        = update1_tag;
        write_entry.lower      = update1_lower;
        write_entry.upct_index = update1_index;
    end

    // ----------------------------------------------------------------------
    // table

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            entries <= '0;
        end else if (update1_valid) begin
            entries[update1_set] <= write_entry;
        end
    end

    // ----------------------------------------------------------------------
    // lookup read

    assign lookup_set = lookup.pc[7:2];
    assign lookup_tag = lookup.pc[15:8];
    assign read_entry = entries[lookup_set];

    always_comb begin
        result.valid      = lookup.valid;
        result.hit        = lookup.valid && read_entry.valid && (read_entry.tag == lookup_tag);
        result.lower      = read_entry.lower;
        result.upct_index = read_entry.upct_index;
    end

endmodule

`default_nettype wire

// ==== rtl/target_assembler.sv ====
// response stage register, full target assembly and upct read touch
`timescale 1ns/1ns
`default_nettype none

module target_assembler (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  btc_pkg::lookup_result_t                         result,
    input  btc_pkg::upper_pc_t [btc_pkg::UPCT_ENTRIES-1:0]  upct_array,
    output btc_pkg::pred_resp_t                             pred,
    output logic                                            read_valid,
    output btc_pkg::upct_index_t                            read_index
);

    // response stage
    btc_pkg::lookup_result_t resp;

    // ----------------------------------------------------------------------
    // resp register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            resp <= '0;
        end else begin
            resp <= result;
        end
    end

    // ----------------------------------------------------------------------
    // prediction out

    // upper field is read now, so a replacement in between shows through
    always_comb begin
        pred.valid  = resp.valid;
        pred.hit    = resp.hit;
        pred.target = {upct_array[resp.upct_index], resp.lower};
    end

    // touch used entry so it stays out of replacement
    assign read_valid = resp.valid && resp.hit;
    assign read_index = resp.upct_index;

endmodule

`default_nettype wire

// ==== rtl/branch_target_cache.sv ====
// branch target cache top with lower table, upct and target assembler
`timescale 1ns/1ns
`default_nettype none

module branch_target_cache (
    input  logic                 CLK,
    input  logic                 nRST,
    input  btc_pkg::lookup_req_t lookup,
    input  btc_pkg::update_req_t update,
    output btc_pkg::pred_resp_t  pred
);

    btc_pkg::upper_pc_t [btc_pkg::UPCT_ENTRIES-1:0] upct_array;
    btc_pkg::upct_index_t                           update1_index;
    btc_pkg::lookup_result_t                        result;
    logic                                           read_valid;
    btc_pkg::upct_index_t                           read_index;

    // ----------------------------------------------------------------------
    // upper field storage

    upct u_upct (
        .CLK            (CLK),
        .nRST           (nRST),
        .update0_valid  (update.valid),
        .update0_target (update.target),
        .read_valid     (read_valid),
        .read_index     (read_index),
        .upct_array     (upct_array),
        .update1_index  (update1_index)
    );

    // ----------------------------------------------------------------------
    // per-branch lower bits

    btb_lower_table u_lower_table (
        .CLK           (CLK),
        .nRST          (nRST),
        .lookup        (lookup),
        .update        (update),
        .update1_index (update1_index),
        .result        (result)
    );

    // ----------------------------------------------------------------------
    // response

    target_assembler u_assembler (
        .CLK        (CLK),
        .nRST       (nRST),
        .result     (result),
        .upct_array (upct_array),
        .pred       (pred),
        .read_valid (read_valid),
        .read_index (read_index)
    );

endmodule

`default_nettype wire

// ==== verif/branch_target_cache_tb.sv ====
// testbench for the branch target cache with clock, reset, stimulus, reference model and assertions
`timescale 1ns/1ns
`default_nettype none

module branch_target_cache_tb;

    logic                 CLK;
    logic                 nRST;
    btc_pkg::lookup_req_t lookup;
    btc_pkg::update_req_t update;
    btc_pkg::pred_resp_t  pred;

    int unsigned errors;
    int unsigned checks;
    logic [31:0] lcg_state;

    // reference model state
    logic                   m_valid [btc_pkg::BTB_SETS];
    btc_pkg::btb_tag_t      m_tag   [btc_pkg::BTB_SETS];
    btc_pkg::lower_pc_t     m_lower [btc_pkg::BTB_SETS];
    btc_pkg::upct_index_t   m_idx   [btc_pkg::BTB_SETS];
    btc_pkg::upper_pc_t [btc_pkg::UPCT_ENTRIES-1:0] m_upct;
    btc_pkg::plru_bits_t    m_plru;
    logic                   s1_valid;
    btc_pkg::btb_index_t    s1_set;
    btc_pkg::btb_tag_t      s1_tag;
    btc_pkg::lower_pc_t     s1_lower;
    btc_pkg::upper_pc_t     s1_upper;
    logic [btc_pkg::UPCT_ENTRIES-1:0] s1_match;
    logic                   r_valid;
    logic                   r_hit;
    btc_pkg::lower_pc_t     r_lower;
    btc_pkg::upct_index_t   r_idx;
    btc_pkg::upct_index_t   miss_order [$];

    logic         exp_valid;
    logic         exp_hit;
    btc_pkg::pc_t exp_target;

    branch_target_cache uut (
        .CLK    (CLK),
        .nRST   (nRST),
        .lookup (lookup),
        .update (update),
        .pred   (pred)
    );

    always #4 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic btc_pkg::pc_t pc_of(btc_pkg::btb_index_t set, btc_pkg::btb_tag_t tag);
        return {16'h0000, tag, set, 2'b00};
    endfunction

    // walk from the root where a 0 bit sends the victim to the lower half
    function automatic btc_pkg::upct_index_t victim_of(btc_pkg::plru_bits_t p);
        int                   node;
        btc_pkg::upct_index_t idx;
        node = 0;
        idx  = '0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            idx  = {idx[1:0], p[node]};
            node = 2 * node + 1 + int'(p[node]);
        end
        return idx;
    endfunction

    function automatic btc_pkg::plru_bits_t point_away(btc_pkg::plru_bits_t p,
                                                       btc_pkg::upct_index_t idx);
        int   node;
        logic b;
        node = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            b       = idx[2-lvl];
            p[node] = ~b;
            node    = 2 * node + 1 + int'(b);
        end
        return p;
    endfunction

    // ----------------------------------------------------------------------
    // reference model stepping once per clock

    always @(posedge CLK or negedge nRST) begin : model
        logic [btc_pkg::UPCT_ENTRIES-1:0] new_match;
        logic                 n_hit;
        btc_pkg::lower_pc_t   n_lower;
        btc_pkg::upct_index_t n_idx;
        btc_pkg::upct_index_t wi;
        if (!nRST) begin
            for (int i = 0; i < btc_pkg::BTB_SETS; i++) begin
                m_valid[i] = 1'b0;
                m_tag[i]   = '0;
                m_lower[i] = '0;
                m_idx[i]   = '0;
            end
            m_upct   = '0;
            m_plru   = '0;
            s1_valid = 1'b0;
            r_valid  = 1'b0;
            r_hit    = 1'b0;
            r_lower  = '0;
            r_idx    = '0;
            miss_order.delete();
        end else begin
            if (r_valid) begin
                checks++;
            end
            for (int i = 0; i < btc_pkg::UPCT_ENTRIES; i++) begin
                new_match[i] = (m_upct[i] == update.target[31:22]);
            end
            // lookup reads the table before this cycle's write
            n_hit   = lookup.valid && m_valid[lookup.pc[7:2]]
                      && (m_tag[lookup.pc[7:2]] == lookup.pc[15:8]);
            n_lower = m_lower[lookup.pc[7:2]];
            n_idx   = m_idx[lookup.pc[7:2]];
            if (s1_valid) begin
                wi = '0;
                if (|s1_match) begin
                    for (int i = btc_pkg::UPCT_ENTRIES - 1; i >= 0; i--) begin
                        if (s1_match[i]) begin
                            wi = btc_pkg::upct_index_t'(i);
                        end
                    end
                end else begin
                    wi         = victim_of(m_plru);
                    m_upct[wi] = s1_upper;
                    miss_order.push_back(wi);
                end
                m_plru          = point_away(m_plru, wi);
                m_valid[s1_set] = 1'b1;
                m_tag[s1_set]   = s1_tag;
                m_lower[s1_set] = s1_lower;
                m_idx[s1_set]   = wi;
            end else if (r_valid && r_hit) begin
                m_plru = point_away(m_plru, r_idx);
            end
            r_valid  = lookup.valid;
            r_hit    = n_hit;
            r_lower  = n_lower;
            r_idx    = n_idx;
            s1_valid = update.valid;
            s1_set   = update.pc[7:2];
            s1_tag   = update.pc[15:8];
            s1_lower = update.target[21:0];
            s1_upper = update.target[31:22];
            s1_match = new_match;
        end
    end

    assign exp_valid  = r_valid;
    assign exp_hit    = r_hit;
    assign exp_target = {m_upct[r_idx], r_lower};

    // ----------------------------------------------------------------------
    // checks

    a_pred_valid: assert property (@(posedge CLK) disable iff (!nRST) pred.valid == exp_valid)
        else begin
            errors++;
            $display("FAIL t=%0t pred.valid got %0b expected %0b",
                     $time, $sampled(pred.valid), $sampled(exp_valid));
        end

    a_pred_hit: assert property (@(posedge CLK) disable iff (!nRST)
                                 exp_valid |-> pred.hit == exp_hit)
        else begin
            errors++;
            $display("FAIL t=%0t pred.hit got %0b expected %0b",
                     $time, $sampled(pred.hit), $sampled(exp_hit));
        end

    a_pred_target: assert property (@(posedge CLK) disable iff (!nRST)
                                    (exp_valid && exp_hit) |-> pred.target == exp_target)
        else begin
            errors++;
            $display("FAIL t=%0t pred.target got %h expected %h",
                     $time, $sampled(pred.target), $sampled(exp_target));
        end

    a_upct_array: assert property (@(posedge CLK) disable iff (!nRST)
                                   uut.upct_array == m_upct)
        else begin
            errors++;
            $display("FAIL t=%0t upct_array got %h expected %h",
                     $time, $sampled(uut.upct_array), $sampled(m_upct));
        end

    // ----------------------------------------------------------------------
    // stimulus tasks

    task automatic drive(input logic lv, input btc_pkg::pc_t lpc,
                         input logic uv, input btc_pkg::pc_t upc, input btc_pkg::pc_t utgt);
        @(posedge CLK);
        lookup.valid  <= lv;
        lookup.pc     <= lpc;
        update.valid  <= uv;
        update.pc     <= upc;
        update.target <= utgt;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            drive(1'b0, '0, 1'b0, '0, '0);
        end
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        nRST   <= 1'b0;
        lookup <= '0;
        update <= '0;
        for (int i = 0; i < 2; i++) begin
            @(posedge CLK);
        end
        nRST <= 1'b1;
    endtask

    task automatic lookup_wait(input btc_pkg::pc_t pc);
        int n;
        drive(1'b1, pc, 1'b0, '0, '0);
        @(posedge CLK);
        lookup.valid <= 1'b0;
        n = 0;
        @(negedge CLK);
        while (!pred.valid && n < 4) begin
            @(negedge CLK);
            n++;
        end
        if (!pred.valid) begin
            errors++;
            $display("no response came back for the lookup of pc %h", pc);
        end
    endtask

    // ----------------------------------------------------------------------
    // test sequence

    initial begin : watchdog
        int n;
        n = 0;
        while (n < 20000) begin
            @(posedge CLK);
            n++;
        end
        $display("simulation did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        btc_pkg::upct_index_t expected_order [8];
        logic [31:0] r;
        logic [31:0] r2;
        int          cnt;
        expected_order = '{3'd0, 3'd4, 3'd2, 3'd6, 3'd1, 3'd5, 3'd3, 3'd7};
        CLK       = 1'b0;
        nRST      = 1'b0;
        lookup    = '0;
        update    = '0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'd53;
        apply_reset();

        // empty table misses everywhere
        for (int i = 0; i < 8; i++) begin
            lookup_wait(pc_of(btc_pkg::btb_index_t'(lcg_next()), 8'h3c));
        end

        // update then lookup two cycles later, and a tag mismatch
        drive(1'b0, '0, 1'b1, pc_of(6'd5, 8'h21), 32'h5551_2344);
        idle(1);
        lookup_wait(pc_of(6'd5, 8'h21));
        lookup_wait(pc_of(6'd5, 8'h22));

        // shared upper field takes one upct entry
        for (int i = 0; i < 3; i++) begin
            drive(1'b0, '0, 1'b1, pc_of(btc_pkg::btb_index_t'(10 + i), 8'h40),
                  {10'h3a0, 22'(i * 4096 + 8)});
            idle(1);
        end
        idle(2);
        for (int i = 0; i < 3; i++) begin
            lookup_wait(pc_of(btc_pkg::btb_index_t'(10 + i), 8'h40));
        end
        cnt = 0;
        for (int i = 0; i < btc_pkg::UPCT_ENTRIES; i++) begin
            if (m_upct[i] == 10'h3a0) begin
                cnt++;
            end
        end
        assert (cnt == 1) else begin
            errors++;
            $display("FAIL t=%0t shared upper field entries got %0d expected 1", $time, cnt);
        end

        // fill order from reset, then a ninth upper field
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            drive(1'b0, '0, 1'b1, pc_of(btc_pkg::btb_index_t'(i), 8'h11),
                  {10'(10'h200 + i), 22'(i * 4096 + 5)});
            idle(1);
        end
        idle(1);
        @(negedge CLK);
        assert (miss_order.size() == 8) else begin
            errors++;
            $display("FAIL t=%0t upct fill writes got %0d expected 8",
                     $time, miss_order.size());
        end
        for (int i = 0; i < 8 && i < miss_order.size(); i++) begin
            assert (miss_order[i] == expected_order[i]) else begin
                errors++;
                $display("FAIL t=%0t fill order %0d got %0d expected %0d",
                         $time, i, miss_order[i], expected_order[i]);
            end
        end
        drive(1'b0, '0, 1'b1, pc_of(6'd8, 8'h11), {10'h2f0, 22'h00abc});
        idle(2);
        for (int i = 0; i < 9; i++) begin
            lookup_wait(pc_of(btc_pkg::btb_index_t'(i), 8'h11));
        end

        // touches steer the victim, then back-to-back updates
        lookup_wait(pc_of(6'd3, 8'h11));
        lookup_wait(pc_of(6'd6, 8'h11));
        drive(1'b0, '0, 1'b1, pc_of(6'd20, 8'h11), {10'h2f1, 22'h00123});
        idle(2);
        lookup_wait(pc_of(6'd20, 8'h11));
        drive(1'b0, '0, 1'b1, pc_of(6'd2, 8'h11), {10'h2f2, 22'h01111});
        drive(1'b1, pc_of(6'd2, 8'h11), 1'b1, pc_of(6'd4, 8'h11), {10'h2f3, 22'h02222});
        drive(1'b1, pc_of(6'd4, 8'h11), 1'b0, '0, '0);
        idle(2);
        lookup_wait(pc_of(6'd2, 8'h11));
        lookup_wait(pc_of(6'd4, 8'h11));

        // random mix over four sets and two tags
        for (int i = 0; i < 400; i++) begin
            r  = lcg_next();
            r2 = lcg_next();
            drive(r[0], pc_of(btc_pkg::btb_index_t'(r[2:1]), {7'h08, r[3]}),
                  r[4] & r[5],
                  pc_of(btc_pkg::btb_index_t'(r[7:6]), {7'h08, r[8]}),
                  {10'(10'h100 + (r[14:9] % 12)), 22'(r2[14:0] * 131)});
        end
        idle(3);

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== branch_target_cache.f ====
rtl/btc_pkg.sv
rtl/plru_updater.sv
rtl/upct.sv
rtl/btb_lower_table.sv
rtl/target_assembler.sv
rtl/branch_target_cache.sv
verif/branch_target_cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the branch target cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    -f branch_target_cache.f \
    --top-module branch_target_cache_tb \
    --Mdir obj_dir -o branch_target_cache_sim
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

sim_output=$(./obj_dir/branch_target_cache_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
